//--- drac_bus_pkg.sv
`include "drac_config.svh"

package drac_bus_pkg;

    // host register address
    // [7:4] channel (0 board, 1..n motors), [3:0] offset
    typedef logic [15:0] reg_addr_t;

    typedef logic [31:0] reg_data_t;    // one quadlet

    typedef logic [3:0] chan_t;         // channel field of reg_addr_t
    typedef logic [3:0] reg_off_t;      // offset field of reg_addr_t

    // sample buffer index
    typedef logic [`DRAC_SAMPLE_AW-1:0] sample_addr_t;

endpackage

//--- drac_config.svh
`ifndef DRAC_CONFIG_SVH
`define DRAC_CONFIG_SVH

// motor channels on the board
`define DRAC_NUM_MOTORS 4

// sysclk cycles per watchdog period unit
`define DRAC_WDOG_TICK 16

// sample buffer address width
// 1 timestamp + 1 entry per motor, 8 slots
`define DRAC_SAMPLE_AW 3

`endif

//--- drac_motor_pkg.sv
package drac_motor_pkg;

    typedef logic [15:0] dac_t;         // motor current setpoint
    typedef logic [15:0] fb_t;          // feedback from ADC side
    typedef logic [15:0] wdog_units_t;  // watchdog period, in ticks

    // sample capture
    typedef enum logic {
        SMP_IDLE,
        SMP_CAPTURE
    } sampler_state_t;

    // real-time block write decode
    typedef enum logic [1:0] {
        BLK_IDLE,       // no block open
        BLK_HEADER,     // waiting for sequence quadlet
        BLK_BODY        // one quadlet per motor
    } blk_state_t;

endpackage

//--- drac_regs.sv
`timescale 1ns/1ps
`include "drac_config.svh"

module drac_regs (
    input  logic                       sysclk,
    input  logic                       arst_n,
    input  drac_bus_pkg::chan_t        board_id,
    input  logic                       wr_wen,
    input  drac_bus_pkg::reg_addr_t    wr_addr,
    input  drac_bus_pkg::reg_data_t    wr_data,
    input  drac_bus_pkg::reg_addr_t    reg_raddr,
    output drac_bus_pkg::reg_data_t    reg_rdata,
    input  drac_bus_pkg::reg_data_t    blk_seq,
    input  drac_motor_pkg::fb_t [`DRAC_NUM_MOTORS-1:0]  feedback,
    input  logic                       wdog_timeout,
    output logic                       wdog_clear,
    output drac_motor_pkg::wdog_units_t wdog_period,
    output drac_motor_pkg::dac_t [`DRAC_NUM_MOTORS-1:0] dac_out,
    output logic [`DRAC_NUM_MOTORS-1:0] motor_enable
);
    import drac_bus_pkg::*;
    import drac_motor_pkg::*;

    localparam reg_off_t OFF_STATUS = 4'h0;   // board status / motor command
    localparam reg_off_t OFF_SEQ    = 4'h1;   // board only
    localparam reg_off_t OFF_FB     = 4'h2;   // motor only
    localparam reg_off_t OFF_WDOG   = 4'h3;   // board only

    chan_t     wr_chan;
    reg_off_t  wr_off;
    logic      wr_hit;      // address within the decoded page
    chan_t     rd_chan;
    reg_off_t  rd_off;
    reg_data_t rd_next;

    assign wr_chan = wr_addr[7:4];
    assign wr_off  = wr_addr[3:0];
    assign wr_hit  = wr_wen && (wr_addr[15:8] == 8'h00);
    assign rd_chan = reg_raddr[7:4];
    assign rd_off  = reg_raddr[3:0];

    // status write with bit 0 set
    assign wdog_clear = wr_hit && (wr_chan == '0) && (wr_off == OFF_STATUS) && wr_data[0];

    // board registers
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wdog_period <= '0;      // watchdog off
        end else if (wr_hit && (wr_chan == '0) && (wr_off == OFF_WDOG)) begin
            wdog_period <= wr_data[15:0];
        end
    end

    // motor setpoints and enables
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            dac_out      <= '0;
            motor_enable <= '0;
        end else begin
            for (int i = 0; i < `DRAC_NUM_MOTORS; i++) begin
                if (wr_hit && (wr_chan == chan_t'(i + 1)) && (wr_off == OFF_STATUS)) begin
                    if (wr_data[31]) begin
                        dac_out[i] <= wr_data[15:0];        // dac load
                    end
                    if (wr_data[28] && !wdog_timeout) begin
                        motor_enable[i] <= wr_data[29];     // enable load
                    end
                end
            end
            if (wdog_timeout) begin
                motor_enable <= '0;     // amps held off until cleared
            end
        end
    end

    // read mux
    always_comb begin
        rd_next = '0;   // unmapped reads 0
        if (reg_raddr[15:8] == 8'h00) begin
            if (rd_chan == '0) begin
                case (rd_off)
                    OFF_STATUS: rd_next = {wdog_timeout, 3'b000, board_id, 16'h0000,
                                           8'(`DRAC_NUM_MOTORS)};
                    OFF_SEQ:    rd_next = blk_seq;
                    OFF_WDOG:   rd_next = {16'h0000, wdog_period};
                    default:    rd_next = '0;
                endcase
            end else begin
                for (int i = 0; i < `DRAC_NUM_MOTORS; i++) begin
                    if (rd_chan == chan_t'(i + 1)) begin
                        if (rd_off == OFF_STATUS) begin
                            rd_next = {2'b00, motor_enable[i], 13'h0000, dac_out[i]};
                        end else if (rd_off == OFF_FB) begin
                            rd_next = {16'h0000, feedback[i]};
                        end
                    end
                end
            end
        end
    end

    always_ff @(posedge sysclk) begin
        reg_rdata <= rd_next;   // one cycle read latency
    end

endmodule

//--- drac_tests.txt
# op args in hex: W addr data | B seq q1 q2 q3 q4 [q5] | R addr expected | D cycles
# F motor feedback | S entry1 entry2 entry3 entry4 | T starts a named test
T reset
R 0000 05000004
R 0010 00000000
R 0040 00000000
R 0003 00000000
T single_write
W 0010 b0001234
W 0010 80005678
R 0010 20005678
W 0010 10000000
R 0010 00005678
W 0020 30000abc
R 0020 20000000
T block_write
B 0000002a b0001111 b0002222 80003333 b0004444 b0009999
R 0010 20001111
R 0020 20002222
R 0030 00003333
R 0040 20004444
R 0001 0000002a
T watchdog
W 0003 00000002
D 30
R 0000 85000004
R 0010 00001111
R 0040 00004444
W 0010 30000000
R 0010 00001111
W 0000 00000001
W 0010 30000000
R 0010 20001111
W 0030 80000301
D 0a
W 0030 80000302
D 0a
W 0030 80000303
D 0a
W 0030 80000304
R 0000 05000004
W 0003 00000000
T sample
F 1 0000a001
F 2 0000a002
F 3 0000a003
F 4 0000a004
S a0011111 a0022222 a0030304 a0044444
W 0020 80002020
S a0011111 a0022020 a0030304 a0044444
T readback
R 0012 0000a001
R 0022 0000a002
R 0042 0000a004
R 0002 00000000
R 0050 00000000
R 0110 00000000

//--- drac_top.sv
`timescale 1ns/1ps
`include "drac_config.svh"

module drac_top (
    input  logic                           sysclk,
    input  logic                           arst_n,
    input  drac_bus_pkg::chan_t            board_id,
    input  drac_bus_pkg::reg_addr_t        reg_raddr,
    output drac_bus_pkg::reg_data_t        reg_rdata,
    input  drac_bus_pkg::reg_addr_t        reg_waddr,
    input  drac_bus_pkg::reg_data_t        reg_wdata,
    input  logic                           reg_wen,
    input  logic                           blk_wen,
    input  logic                           blk_wstart,
    input  logic [`DRAC_NUM_MOTORS*16-1:0] feedback,       // motor 1 in bits 15:0
    input  logic                           sample_start,
    output logic                           sample_busy,
    input  drac_bus_pkg::sample_addr_t     sample_raddr,
    output drac_bus_pkg::reg_data_t        sample_rdata,
    output logic [`DRAC_NUM_MOTORS*16-1:0] dac_out,        // motor 1 in bits 15:0
    output logic [`DRAC_NUM_MOTORS-1:0]    motor_enable,
    output logic                           wdog_timeout
);
    import drac_bus_pkg::*;
    import drac_motor_pkg::*;

    logic        wr_wen;        // merged write stream
    reg_addr_t   wr_addr;
    reg_data_t   wr_data;
    reg_data_t   blk_seq;
    logic        wdog_clear;
    wdog_units_t wdog_period;

    reg_bus_if bus ();  // host write bus

    assign bus.waddr      = reg_waddr;
    assign bus.wdata      = reg_wdata;
    assign bus.wen        = reg_wen;
    assign bus.blk_wen    = blk_wen;
    assign bus.blk_wstart = blk_wstart;

    write_rt_data u_write_rt_data (
        .sysclk  (sysclk),
        .arst_n  (arst_n),
        .bus     (bus),
        .wr_wen  (wr_wen),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .blk_seq (blk_seq)
    );

    drac_regs u_drac_regs (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .board_id     (board_id),
        .wr_wen       (wr_wen),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .reg_raddr    (reg_raddr),
        .reg_rdata    (reg_rdata),
        .blk_seq      (blk_seq),
        .feedback     (feedback),
        .wdog_timeout (wdog_timeout),
        .wdog_clear   (wdog_clear),
        .wdog_period  (wdog_period),
        .dac_out      (dac_out),
        .motor_enable (motor_enable)
    );

    // every merged write counts as host activity
    wdog_timer u_wdog_timer (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .wdog_kick    (wr_wen),
        .wdog_clear   (wdog_clear),
        .wdog_period  (wdog_period),
        .wdog_timeout (wdog_timeout)
    );

    rt_sampler u_rt_sampler (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .sample_start (sample_start),
        .feedback     (feedback),
        .dac_out      (dac_out),
        .sample_busy  (sample_busy),
        .sample_raddr (sample_raddr),
        .sample_rdata (sample_rdata)
    );

endmodule

//--- reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if;
    import drac_bus_pkg::*;

    reg_addr_t waddr;       // write address
    reg_data_t wdata;       // write data
    logic      wen;         // one quadlet this cycle
    logic      blk_wen;     // quadlet belongs to a block write
    logic      blk_wstart;  // block about to start

    // link side, drives the bus
    modport host (
        output waddr,
        output wdata,
        output wen,
        output blk_wen,
        output blk_wstart
    );

    // write decoder side
    modport decoder (
        input waddr,
        input wdata,
        input wen,
        input blk_wen,
        input blk_wstart
    );

endinterface

//--- rt_sampler.sv
`timescale 1ns/1ps
`include "drac_config.svh"

module rt_sampler (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic                        sample_start,
    input  drac_motor_pkg::fb_t [`DRAC_NUM_MOTORS-1:0]  feedback,
    input  drac_motor_pkg::dac_t [`DRAC_NUM_MOTORS-1:0] dac_out,
    output logic                        sample_busy,
    input  drac_bus_pkg::sample_addr_t  sample_raddr,
    output drac_bus_pkg::reg_data_t     sample_rdata
);
    import drac_bus_pkg::*;
    import drac_motor_pkg::*;

    localparam int DEPTH = 2 ** `DRAC_SAMPLE_AW;

    sampler_state_t state;
    sample_addr_t   cap_idx;        // entry written this cycle
    reg_data_t      cap_data;
    logic [31:0]    timestamp;      // free running
    reg_data_t      sample_buf [DEPTH];

    assign sample_busy = (state == SMP_CAPTURE);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            timestamp <= '0;
        end else begin
            timestamp <= timestamp + 1'b1;
        end
    end

    // one entry per cycle, timestamp first
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= SMP_IDLE;
            cap_idx <= '0;
        end else begin
            case (state)
                SMP_IDLE: begin
                    if (sample_start) begin
                        state   <= SMP_CAPTURE;
                        cap_idx <= '0;
                    end
                end
                SMP_CAPTURE: begin
                    cap_idx <= cap_idx + 1'b1;
                    if (cap_idx == sample_addr_t'(`DRAC_NUM_MOTORS)) begin
                        state <= SMP_IDLE;      // last motor written
                    end
                end
                default: state <= SMP_IDLE;
            endcase
        end
    end

    // entry k: feedback k high, setpoint k low
    always_comb begin
        cap_data = timestamp;
        for (int i = 0; i < `DRAC_NUM_MOTORS; i++) begin
            if (cap_idx == sample_addr_t'(i + 1)) begin
                cap_data = {feedback[i], dac_out[i]};
            end
        end
    end

    always_ff @(posedge sysclk) begin
        if (state == SMP_CAPTURE) begin
            sample_buf[cap_idx] <= cap_data;
        end
        sample_rdata <= sample_buf[sample_raddr];   // registered read port
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_drac -f sources.f -o sim_drac \
    && ./obj_dir/sim_drac | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null \
    && echo "run_sim.sh: simulation passed" \
    || { echo "run_sim.sh: simulation failed"; exit 1; }

//--- sources.f
+incdir+.
drac_bus_pkg.sv
drac_motor_pkg.sv
reg_bus_if.sv
write_rt_data.sv
drac_regs.sv
wdog_timer.sv
rt_sampler.sv
drac_top.sv
tb_drac.sv

//--- tb_drac.sv
`timescale 1ns/1ps
`include "drac_config.svh"

module tb_drac;
    localparam int NM = `DRAC_NUM_MOTORS;
    localparam int SAW = `DRAC_SAMPLE_AW;
    localparam int BUSY_LIMIT = 4 * NM + 8;    // generous bound on a capture

    typedef logic [SAW-1:0] saddr_t;

    logic              sysclk;
    logic              arst_n;
    logic [3:0]        board_id;
    logic [15:0]       reg_raddr;
    logic [31:0]       reg_rdata;
    logic [15:0]       reg_waddr;
    logic [31:0]       reg_wdata;
    logic              reg_wen;
    logic              blk_wen;
    logic              blk_wstart;
    logic [NM*16-1:0]  feedback;       // motor 1 in bits 15:0
    logic              sample_start;
    logic              sample_busy;
    saddr_t            sample_raddr;
    logic [31:0]       sample_rdata;
    logic [NM*16-1:0]  dac_out;
    logic [NM-1:0]     motor_enable;
    logic              wdog_timeout;

    int          errors;        // whole run
    int          test_errors;   // current test only
    int          tests_run;
    int          tests_failed;
    string       test_name;
    logic [31:0] last_ts;       // entry 0 of previous sample

    drac_top u_dut (.*);

    always #20 sysclk = ~sysclk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        errors++;
        test_errors++;
    endtask

    // inputs always change 2 ns after the edge
    task automatic next_cycle();
        @(posedge sysclk);
        #2;
    endtask

    // all outputs low straight out of reset
    task automatic check_idle_outputs();
        for (int k = 1; k <= NM; k++) begin
            check($sformatf("dac_out[%0d]", k), {16'h0, dac_out[(k-1)*16 +: 16]}, 32'h0);
        end
        check("motor_enable", 32'(motor_enable), 32'h0);
        check("sample_busy", {31'h0, sample_busy}, 32'h0);
        check("wdog_timeout", {31'h0, wdog_timeout}, 32'h0);
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        next_cycle();
        reg_waddr = addr[15:0];
        reg_wdata = data;
        reg_wen   = 1'b1;
        next_cycle();
        reg_wen   = 1'b0;
    endtask

    // quads[0] is the sequence number, the rest go to motors 1..n
    task automatic block_write(input logic [31:0] quads [6], input int count);
        next_cycle();
        blk_wstart = 1'b1;
        next_cycle();
        blk_wstart = 1'b0;
        reg_wen    = 1'b1;
        blk_wen    = 1'b1;
        for (int k = 0; k < count; k++) begin
            reg_wdata = quads[k];
            next_cycle();
        end
        reg_wen = 1'b0;
        blk_wen = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp);
        int ch;
        ch = int'(addr[7:4]);
        next_cycle();
        reg_raddr = addr[15:0];
        next_cycle();                                   // registered read data
        check($sformatf("reg_rdata @%04h", addr[15:0]), reg_rdata, exp);
        if (addr[15:8] == 8'h00 && addr[3:0] == 4'h0) begin
            if (ch == 0) begin
                check("wdog_timeout", {31'h0, wdog_timeout}, {31'h0, exp[31]});
            end else if (ch <= NM) begin                // outputs must match the readback
                check($sformatf("dac_out[%0d]", ch), {16'h0, dac_out[(ch-1)*16 +: 16]},
                      {16'h0, exp[15:0]});
                check($sformatf("motor_enable[%0d]", ch), {31'h0, motor_enable[ch-1]},
                      {31'h0, exp[29]});
            end
        end
    endtask

    task automatic set_feedback(input int ch, input logic [31:0] value);
        next_cycle();
        if (ch >= 1 && ch <= NM) begin
            feedback[(ch-1)*16 +: 16] = value[15:0];
        end else begin
            report_error($sformatf("feedback channel %0d does not exist", ch));
        end
    endtask

    // exp[0..3] are entries 1..4, entry 0 must move forward
    task automatic sample_check(input logic [31:0] exp [6]);
        int          waited;
        logic [31:0] ts;
        ts = '0;
        next_cycle();
        sample_start = 1'b1;
        next_cycle();
        sample_start = 1'b0;
        check("sample_busy", {31'h0, sample_busy}, 32'h1);    // up on the start edge
        waited = 0;
        while (sample_busy && waited < BUSY_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (sample_busy) begin
            report_error("sample_busy stayed high, the capture never finished");
        end
        check("sample_busy cycles", 32'(waited), 32'(NM + 1));
        for (int k = 0; k <= NM; k++) begin
            sample_raddr = saddr_t'(k);
            next_cycle();
            if (k == 0) ts = sample_rdata;
            else check($sformatf("sample_rdata[%0d]", k), sample_rdata, exp[k-1]);
        end
        if ($isunknown(ts) || ts <= last_ts) begin
            report_error("sample timestamp did not advance past the previous sample");
        end
        last_ts = ts;
    endtask

    task automatic close_test();
        if (test_name != "") begin
            tests_run++;
            if (test_errors == 0) begin
                $display("test %s: ok", test_name);
            end else begin
                $display("test %s: %0d check(s) failed", test_name, test_errors);
                tests_failed++;
            end
        end
        test_errors = 0;
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        string       op;
        logic [31:0] args [6];
        sysclk       = 1'b0;
        arst_n       = 1'b0;
        board_id     = 4'h5;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        blk_wstart   = 1'b0;
        feedback     = '0;
        sample_start = 1'b0;
        sample_raddr = '0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "";
        last_ts      = '0;
        for (int k = 0; k < 6; k++) args[k] = '0;
        repeat (4) @(posedge sysclk);
        #2 arst_n = 1'b1;
        test_name = "power_up";
        check_idle_outputs();
        fd = $fopen("drac_tests.txt", "r");
        if (fd == 0) begin
            report_error("cannot open drac_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    n = $sscanf(line, "%s", op);
                    if (n > 0 && op != "#") begin
                        if (op == "T") begin
                            close_test();
                            n = $sscanf(line, "%s %s", op, test_name);
                        end else begin
                            n = $sscanf(line, "%s %h %h %h %h %h %h", op, args[0], args[1],
                                        args[2], args[3], args[4], args[5]);
                            case (op)
                                "W": write_reg(args[0], args[1]);
                                "B": block_write(args, n - 1);
                                "R": read_reg(args[0], args[1]);
                                "F": set_feedback(int'(args[0]), args[1]);
                                "S": sample_check(args);
                                "D": repeat (int'(args[0])) next_cycle();
                                default: report_error($sformatf("unknown opcode %s", op));
                            endcase
                        end
                    end
                end
            end
            close_test();
            $fclose(fd);
        end
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- wdog_timer.sv
`timescale 1ns/1ps
`include "drac_config.svh"

module wdog_timer (
    input  logic                        sysclk,
    input  logic                        arst_n,
    input  logic                        wdog_kick,
    input  logic                        wdog_clear,
    input  drac_motor_pkg::wdog_units_t wdog_period,
    output logic                        wdog_timeout
);
    import drac_motor_pkg::*;

    localparam int TICK_W = $clog2(`DRAC_WDOG_TICK);

    logic [TICK_W-1:0] tick_cnt;    // prescaler
    logic              tick;        // one unit elapsed
    wdog_units_t       unit_cnt;    // units since last kick

    assign tick = (tick_cnt == TICK_W'(`DRAC_WDOG_TICK - 1));

    // prescaler and unit counter, both restart on a host write
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
            unit_cnt <= '0;
        end else if (wdog_kick) begin
            tick_cnt <= '0;
            unit_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;    // wraps at tick length
            if (tick && (unit_cnt < wdog_period)) begin
                unit_cnt <= unit_cnt + 1'b1;    // stops at period
            end
        end
    end

    // sticky flag, clear wins over a fresh expiry
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wdog_timeout <= 1'b0;
        end else if (wdog_clear) begin
            wdog_timeout <= 1'b0;
        end else if ((wdog_period != '0) && (unit_cnt >= wdog_period)) begin
            wdog_timeout <= 1'b1;
        end
    end

endmodule

//--- write_rt_data.sv
`timescale 1ns/1ps
`include "drac_config.svh"

module write_rt_data (
    input  logic                    sysclk,
    input  logic                    arst_n,
    reg_bus_if.decoder              bus,
    output logic                    wr_wen,
    output drac_bus_pkg::reg_addr_t wr_addr,
    output drac_bus_pkg::reg_data_t wr_data,
    output drac_bus_pkg::reg_data_t blk_seq
);
    import drac_bus_pkg::*;
    import drac_motor_pkg::*;

    localparam reg_off_t MOT_CMD = 4'h0;    // motor command register

    blk_state_t state;
    chan_t      blk_chan;   // motor that gets the next body quadlet
    logic       blk_quad;   // block quadlet on the bus
    logic       blk_fwd;    // block quadlet that turns into a motor write

    assign blk_quad = bus.wen && bus.blk_wen;
    assign blk_fwd  = blk_quad && (state == BLK_BODY);

    // block tracking
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= BLK_IDLE;
            blk_chan <= chan_t'(1);
            blk_seq  <= '0;
        end else if (bus.blk_wstart) begin
            state    <= BLK_HEADER;     // restart, even mid block
            blk_chan <= chan_t'(1);
        end else if (blk_quad) begin
            case (state)
                BLK_HEADER: begin
                    blk_seq <= bus.wdata;   // quadlet 0 is the sequence number
                    state   <= BLK_BODY;
                end
                BLK_BODY: begin
                    blk_chan <= blk_chan + 1'b1;
                    if (blk_chan == chan_t'(`DRAC_NUM_MOTORS)) begin
                        state <= BLK_IDLE;  // extra quadlets dropped
                    end
                end
                default: begin
                    state <= BLK_IDLE;      // stray block quadlet, ignore
                end
            endcase
        end
    end

    // merged write strobe
    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_wen <= 1'b0;
        end else begin
            wr_wen <= (bus.wen && !bus.blk_wen) || blk_fwd;
        end
    end

    // merged address / data, only meaningful with wr_wen
    always_ff @(posedge sysclk) begin
        if (bus.blk_wen) begin
            wr_addr <= {8'h00, blk_chan, MOT_CMD};  // quadlet k -> motor k cmd
        end else begin
            wr_addr <= bus.waddr;
        end
        wr_data <= bus.wdata;
    end

endmodule
